// File: tb.f
src/hwpe_ctrl_pkg.sv
src/engine_pkg.sv
src/ctrl_regfile.sv
src/ctrl_slave.sv
src/seq_source.sv
src/stream_fifo.sv
src/accum_sink.sv
src/hwpe_top.sv
verif/tb_hwpe_top.sv

// File: verif/tb_hwpe_top.sv
`timescale 1ns/100ps

module tb_hwpe_top
  import hwpe_ctrl_pkg::*;
();

  localparam int N_CORES     = 2;
  localparam int N_CONTEXT   = 2;
  localparam int FIFO_DEPTH  = 4;
  localparam int N_JOBS      = 7;
  localparam int CYCLE_LIMIT = 200 * (N_JOBS + 5) + 500;  // Table, pair, two cleared and final job
  localparam int EVT_WAIT    = 200;

  logic               clk_i, rst_ni;
  logic               cfg_req, cfg_wen, cfg_gnt, cfg_r_valid;
  logic [31:0]        cfg_add, cfg_data, cfg_r_data;
  logic [3:0]         cfg_be;
  logic [N_CORES-1:0] cfg_id, cfg_r_id, evt;
  logic               busy;

  // Job table
  string       job_name   [N_JOBS];
  int          job_core   [N_JOBS];
  logic [31:0] job_start  [N_JOBS];
  logic [31:0] job_stride [N_JOBS];
  int          job_count  [N_JOBS];

  logic [15:0] lfsr_state = 16'd49659;
  int          exp_ctx = 0;  // Context the next acquire should return
  int          cycles = 0;
  int          test_errors = 0, error_total = 0, tests_run = 0, tests_failed = 0;
  int          evt_seen [N_CORES] = '{default: 0};
  int          evt_expected [N_CORES] = '{default: 0};

  hwpe_top #(.N_CORES(N_CORES), .N_CONTEXT(N_CONTEXT), .FIFO_DEPTH(FIFO_DEPTH)) uut (
    .clk_i, .rst_ni, .cfg_req_i(cfg_req), .cfg_gnt_o(cfg_gnt), .cfg_add_i(cfg_add),
    .cfg_wen_i(cfg_wen), .cfg_be_i(cfg_be), .cfg_data_i(cfg_data), .cfg_id_i(cfg_id),
    .cfg_r_data_o(cfg_r_data), .cfg_r_valid_o(cfg_r_valid), .cfg_r_id_o(cfg_r_id),
    .evt_o(evt), .busy_o(busy)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // Count every cycle an event bit is high
  always @(posedge clk_i) begin
    for (int i = 0; i < N_CORES; i++) begin
      if (evt[i] === 1'b1) evt_seen[i]++;
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Run aborted, no completion after %0d cycles", cycles);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  // Galois LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic random_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v[i] = lfsr_state[0];
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  // Sum of an arithmetic sequence modulo 2^32
  function automatic logic [31:0] expected_sum(input logic [31:0] start, input logic [31:0] stride,
                                               input int count);
    logic [63:0] n;
    logic [63:0] pairs;
    logic [63:0] total;
    n = 64'(count);
    pairs = (n == 0) ? 64'd0 : n * (n - 1) / 2;
    total = n * start + stride * pairs;
    return total[31:0];
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("[ERROR] %s: expected 0x%08h, actual 0x%08h", name, exp, act);
      test_errors++;
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (test_errors == 0) begin
      $display("Test %s: passed", name);
    end else begin
      $display("Test %s: failed with %0d errors", name, test_errors);
      tests_failed++;
      error_total += test_errors;
    end
    test_errors = 0;
  endtask

  task automatic set_job(input int idx, input string name, input int core,
                         input logic [31:0] start, input logic [31:0] stride, input int count);
    job_name[idx]   = name;
    job_core[idx]   = core;
    job_start[idx]  = start;
    job_stride[idx] = stride;
    job_count[idx]  = count;
  endtask

  task automatic fill_table();
    logic [31:0] r;
    set_job(0, "basic_core0", 0, 32'd1, 32'd1, 10);
    random_bits(10, r);
    set_job(1, "rand_stride_core1", 1, 32'd100, r, 16);
    random_bits(32, r);
    set_job(2, "wrap_sum", 0, 32'hF000_0000, r, 20);
    set_job(3, "count_zero", 1, 32'd5, 32'd3, 0);
    set_job(4, "single_word", 0, 32'hDEAD_BEEF, 32'd7, 1);
    random_bits(8, r);
    set_job(5, "long_core1", 1, 32'd3, r, 50);
    set_job(6, "neg_stride_core0", 0, 32'd1000, 32'hFFFF_FFFF, 5);
  endtask

  // One bus request with its response checked a cycle later
  task automatic bus_access(input bit is_read, input int word, input logic [31:0] data,
                            input int core, output logic [31:0] rdata);
    int waited;
    waited = 0;
    rdata = '0;
    @(posedge clk_i);
    cfg_req  <= 1'b1;
    cfg_wen  <= is_read;
    cfg_add  <= 32'(word) << 2;
    cfg_data <= data;
    cfg_be   <= 4'hF;
    cfg_id   <= N_CORES'(1 << core);
    @(negedge clk_i);
    check_value($sformatf("grant, word %0d", word), 32'd1, 32'(cfg_gnt));
    @(posedge clk_i);
    cfg_req <= 1'b0;
    cfg_wen <= 1'b1;
    @(negedge clk_i);
    while (cfg_r_valid !== 1'b1 && waited < 4) begin
      @(negedge clk_i);
      waited++;
    end
    if (cfg_r_valid !== 1'b1) begin
      $display("No bus response for word %0d from core %0d", word, core);
      test_errors++;
    end else begin
      check_value($sformatf("response id, word %0d", word), 32'(1 << core), 32'(cfg_r_id));
      rdata = cfg_r_data;
    end
  endtask

  task automatic bus_write(input int word, input logic [31:0] data, input int core);
    logic [31:0] unused;
    bus_access(1'b0, word, data, core, unused);
  endtask

  task automatic bus_read(input int word, input int core, output logic [31:0] data);
    bus_access(1'b1, word, 32'd0, core, data);
  endtask

  // Acquire, program and read back a context, then trigger it
  task automatic setup_job(input string name, input int core, input logic [31:0] start,
                           input logic [31:0] stride, input int count);
    logic [31:0] rd;
    bus_read(REG_ACQUIRE, core, rd);
    check_value($sformatf("%s ACQUIRE", name), 32'(exp_ctx), rd);
    bus_write(REG_START, start, core);
    bus_write(REG_STRIDE, stride, core);
    bus_write(REG_COUNT, 32'(count), core);
    bus_read(REG_START, core, rd);
    check_value($sformatf("%s START", name), start, rd);
    bus_read(REG_STRIDE, core, rd);
    check_value($sformatf("%s STRIDE", name), stride, rd);
    bus_read(REG_COUNT, core, rd);
    check_value($sformatf("%s COUNT", name), 32'(count), rd);
    bus_write(REG_TRIGGER, 32'd0, core);
    exp_ctx = (exp_ctx + 1) % N_CONTEXT;
  endtask

  // Done event must be a one-cycle pulse on the triggering core only
  task automatic wait_event(input string name, input int core);
    int waited;
    waited = 0;
    evt_expected[core]++;
    @(negedge clk_i);
    while (evt === '0 && waited < EVT_WAIT) begin
      @(negedge clk_i);
      waited++;
    end
    if (evt === '0) begin
      $display("%s: no done event within %0d cycles", name, EVT_WAIT);
      test_errors++;
    end else begin
      check_value($sformatf("%s evt_o", name), 32'(1 << core), 32'(evt));
      @(negedge clk_i);
      check_value($sformatf("%s evt_o after pulse", name), 32'd0, 32'(evt));
    end
  endtask

  task automatic check_result(input string name, input int core, input logic [31:0] exp);
    logic [31:0] rd;
    bus_read(REG_RESULT, core, rd);
    check_value($sformatf("%s RESULT", name), exp, rd);
  endtask

  initial begin
    logic [31:0] rd;
    logic [31:0] stride_a;
    cfg_req  = 1'b0;
    cfg_wen  = 1'b1;
    cfg_add  = '0;
    cfg_be   = '0;
    cfg_data = '0;
    cfg_id   = '0;
    rst_ni   = 1'b0;
    fill_table();
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);

    check_value("reset_state evt_o", 32'd0, 32'(evt));
    check_value("reset_state busy_o", 32'd0, 32'(busy));
    bus_read(REG_STATUS, 0, rd);
    check_value("reset_state STATUS", 32'd0, rd);
    finish_test("reset_state");

    for (int j = 0; j < N_JOBS; j++) begin
      setup_job(job_name[j], job_core[j], job_start[j], job_stride[j], job_count[j]);
      wait_event(job_name[j], job_core[j]);
      check_result(job_name[j], job_core[j],
                   expected_sum(job_start[j], job_stride[j], job_count[j]));
      bus_read(REG_FINISHED, job_core[j], rd);
      check_value($sformatf("%s FINISHED", job_name[j]), 32'(j + 1), rd);
      bus_read(REG_STATUS, job_core[j], rd);
      check_value($sformatf("%s STATUS", job_name[j]), 32'd0, rd);
      finish_test(job_name[j]);
    end

    // First job runs long enough to keep both contexts busy
    random_bits(12, stride_a);
    setup_job("pair_first", 0, 32'h10, stride_a, 60);
    setup_job("pair_second", 1, 32'h2000, 32'd5, 12);
    bus_read(REG_ACQUIRE, 0, rd);
    check_value("queue_pair third ACQUIRE", 32'(ACQUIRE_FULL), rd);
    bus_read(REG_STATUS, 0, rd);
    check_value("queue_pair STATUS full", 32'd3, rd);
    wait_event("pair_first", 0);
    check_result("pair_first", 0, expected_sum(32'h10, stride_a, 60));
    wait_event("pair_second", 1);
    check_result("pair_second", 1, expected_sum(32'h2000, 32'd5, 12));
    bus_read(REG_FINISHED, 1, rd);
    check_value("queue_pair FINISHED", 32'(N_JOBS + 2), rd);
    bus_read(REG_STATUS, 1, rd);
    check_value("queue_pair STATUS", 32'd0, rd);
    finish_test("queue_pair");

    // Clear hits a running and a queued job that never report done
    setup_job("cleared_run", 1, 32'd1, 32'd1, 100);
    setup_job("cleared_queued", 0, 32'd2, 32'd3, 8);
    bus_read(REG_STATUS, 1, rd);
    check_value("soft_clear STATUS working and full", 32'd3, rd);
    check_value("soft_clear busy_o working", 32'd1, 32'(busy));
    bus_read(REG_RUNNING_CTX, 1, rd);
    check_value("soft_clear RUNNING_CTX before", 32'((N_JOBS + 2) % N_CONTEXT), rd);
    bus_write(REG_SOFT_CLEAR, 32'd1, 1);
    repeat (6) @(posedge clk_i);
    exp_ctx = 0;
    bus_read(REG_FINISHED, 1, rd);
    check_value("soft_clear FINISHED", 32'd0, rd);
    bus_read(REG_STATUS, 1, rd);
    check_value("soft_clear STATUS", 32'd0, rd);
    check_value("soft_clear busy_o", 32'd0, 32'(busy));
    bus_read(REG_RUNNING_CTX, 1, rd);
    check_value("soft_clear RUNNING_CTX", 32'd0, rd);
    random_bits(16, stride_a);
    setup_job("after_clear", 0, 32'd7, stride_a, 9);
    wait_event("after_clear", 0);
    check_result("after_clear", 0, expected_sum(32'd7, stride_a, 9));
    bus_read(REG_FINISHED, 0, rd);
    check_value("after_clear FINISHED", 32'd1, rd);
    finish_test("soft_clear");

    repeat (4) @(posedge clk_i);
    for (int i = 0; i < N_CORES; i++) begin
      check_value($sformatf("event_count core %0d", i), 32'(evt_expected[i]), 32'(evt_seen[i]));
    end
    finish_test("event_count");

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, error_total);
    if (tests_failed == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: src/hwpe_top.sv
`timescale 1ns/100ps

module hwpe_top
  import hwpe_ctrl_pkg::*;
  import engine_pkg::*;
#(
  parameter int unsigned N_CORES    = N_CORES_DEF,
  parameter int unsigned N_CONTEXT  = N_CONTEXT_DEF,
  parameter int unsigned FIFO_DEPTH = 4,
  localparam int unsigned CTX_W     = $clog2(N_CONTEXT)
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               cfg_req_i,
  output logic               cfg_gnt_o,
  input  logic [31:0]        cfg_add_i,
  input  logic               cfg_wen_i,
  input  logic [3:0]         cfg_be_i,
  input  logic [31:0]        cfg_data_i,
  input  logic [N_CORES-1:0] cfg_id_i,
  output logic [31:0]        cfg_r_data_o,
  output logic               cfg_r_valid_o,
  output logic [N_CORES-1:0] cfg_r_id_o,
  output logic [N_CORES-1:0] evt_o,
  output logic               busy_o
);

  logic                      clear, start, done;
  logic                      rf_wen, rf_ren, rf_done;
  logic [REG_ADDR_WIDTH-1:0] rf_addr;
  logic [CTX_W-1:0]          rf_ctx, run_ctx;
  data_t                     rf_wdata, rf_rdata, rf_result, sum;
  logic [STAT_WIDTH-1:0]     stat;
  logic [ACQ_WIDTH-1:0]      acq;
  data_t                     start_val, stride;
  logic [COUNT_WIDTH-1:0]    count;
  logic                      src_valid, src_ready, sink_valid, sink_ready;
  data_t                     src_data, sink_data;

  ctrl_slave #(.N_CORES(N_CORES), .N_CONTEXT(N_CONTEXT)) i_slave (
    .clk_i, .rst_ni, .cfg_req_i, .cfg_gnt_o, .cfg_add_i, .cfg_wen_i, .cfg_be_i,
    .cfg_data_i, .cfg_id_i, .cfg_r_data_o, .cfg_r_valid_o, .cfg_r_id_o,
    .clear_o(clear), .start_o(start), .busy_o, .evt_o, .done_i(done), .result_i(sum),
    .rf_wen_o(rf_wen), .rf_ren_o(rf_ren), .rf_addr_o(rf_addr), .rf_ctx_o(rf_ctx),
    .rf_wdata_o(rf_wdata), .rf_rdata_i(rf_rdata), .rf_done_o(rf_done),
    .rf_result_o(rf_result), .run_ctx_o(run_ctx), .stat_o(stat), .acq_o(acq)
  );

  ctrl_regfile #(.N_CONTEXT(N_CONTEXT)) i_regfile (
    .clk_i, .rst_ni, .clear_i(clear), .wen_i(rf_wen), .ren_i(rf_ren), .addr_i(rf_addr),
    .ctx_i(rf_ctx), .wdata_i(rf_wdata), .rdata_o(rf_rdata), .run_ctx_i(run_ctx),
    .stat_i(stat), .acq_i(acq), .done_i(rf_done), .result_i(rf_result),
    .start_val_o(start_val), .stride_o(stride), .count_o(count)
  );

  seq_source i_source (
    .clk_i, .rst_ni, .clear_i(clear), .start_i(start), .start_val_i(start_val),
    .stride_i(stride), .count_i(count), .valid_o(src_valid), .data_o(src_data),
    .ready_i(src_ready)
  );

  stream_fifo #(.DEPTH(FIFO_DEPTH), .WIDTH(DATA_WIDTH)) i_fifo (
    .clk_i, .rst_ni, .clear_i(clear), .valid_i(src_valid), .data_i(src_data),
    .ready_o(src_ready), .valid_o(sink_valid), .data_o(sink_data), .ready_i(sink_ready)
  );

  accum_sink i_sink (
    .clk_i, .rst_ni, .clear_i(clear), .start_i(start), .count_i(count),
    .valid_i(sink_valid), .data_i(sink_data), .ready_o(sink_ready), .done_o(done),
    .sum_o(sum)
  );

endmodule

// File: src/accum_sink.sv
`timescale 1ns/100ps

module accum_sink
  import engine_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   clear_i,
  input  logic                   start_i,
  input  logic [COUNT_WIDTH-1:0] count_i,
  input  logic                   valid_i,
  input  data_t                  data_i,
  output logic                   ready_o,
  output logic                   done_o,
  output data_t                  sum_o
);

  logic [COUNT_WIDTH-1:0] left_q;  // Words still expected
  data_t                  sum_q;
  logic                   accept;

  assign ready_o = 1'b1;
  assign accept  = valid_i & (left_q != '0);
  assign sum_o   = sum_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      left_q <= '0;
      done_o <= 1'b0;
    end else if (clear_i) begin
      left_q <= '0;
      done_o <= 1'b0;
    end else if (start_i) begin
      left_q <= count_i;
      done_o <= (count_i == '0);  // Empty job finishes right away
    end else begin
      done_o <= accept && (left_q == COUNT_WIDTH'(1));
      if (accept) left_q <= left_q - 1'b1;
    end
  end

  // Accumulator, valid together with done
  always_ff @(posedge clk_i) begin
    if (start_i) sum_q <= '0;
    else if (accept) sum_q <= sum_q + data_i;
  end

endmodule

// File: src/stream_fifo.sv
`timescale 1ns/100ps

module stream_fifo #(
  parameter int unsigned DEPTH = 4,
  parameter int unsigned WIDTH = 32,
  localparam int unsigned PTR_W = $clog2(DEPTH),
  localparam int unsigned CNT_W = $clog2(DEPTH + 1)
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             clear_i,
  input  logic             valid_i,
  input  logic [WIDTH-1:0] data_i,
  output logic             ready_o,
  output logic             valid_o,
  output logic [WIDTH-1:0] data_o,
  input  logic             ready_i
);

  logic [WIDTH-1:0] mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0] fill_q;
  logic             push, pop;

  assign ready_o = (fill_q != CNT_W'(DEPTH));
  assign valid_o = (fill_q != '0);
  assign data_o  = mem_q[rd_ptr_q];
  assign push    = valid_i & ready_o;
  assign pop     = valid_o & ready_i;

  always_ff @(posedge clk_i) begin
    if (push) mem_q[wr_ptr_q] <= data_i;
  end

  // Pointers wrap at DEPTH, which need not be a power of two
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q   <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q   <= '0;
    end else begin
      if (push) wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      if (pop) rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      if (push && !pop) fill_q <= fill_q + 1'b1;
      else if (pop && !push) fill_q <= fill_q - 1'b1;
    end
  end

endmodule

// File: src/seq_source.sv
`timescale 1ns/100ps

module seq_source
  import engine_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   clear_i,
  input  logic                   start_i,
  input  data_t                  start_val_i,
  input  data_t                  stride_i,
  input  logic [COUNT_WIDTH-1:0] count_i,
  output logic                   valid_o,
  output data_t                  data_o,
  input  logic                   ready_i
);

  data_t                  value_q, stride_q;
  logic [COUNT_WIDTH-1:0] remaining_q;
  logic                   accept;

  assign valid_o = (remaining_q != '0);  // Held until the word is taken
  assign accept  = valid_o & ready_i;
  assign data_o  = value_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      remaining_q <= '0;
    end else if (clear_i) begin
      remaining_q <= '0;
    end else if (start_i) begin
      remaining_q <= count_i;
    end else if (accept) begin
      remaining_q <= remaining_q - 1'b1;
    end
  end

  // Sequence value and step
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      value_q  <= start_val_i;
      stride_q <= stride_i;
    end else if (accept) begin
      value_q <= value_q + stride_q;
    end
  end

endmodule

// File: src/ctrl_slave.sv
`timescale 1ns/100ps

module ctrl_slave
  import hwpe_ctrl_pkg::*;
  import engine_pkg::*;
#(
  parameter int unsigned N_CORES   = 2,
  parameter int unsigned N_CONTEXT = 2,
  localparam int unsigned CTX_W    = $clog2(N_CONTEXT),
  localparam int unsigned CORE_W   = (N_CORES > 1) ? $clog2(N_CORES) : 1
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      cfg_req_i,
  output logic                      cfg_gnt_o,
  input  logic [31:0]               cfg_add_i,
  input  logic                      cfg_wen_i,
  input  logic [3:0]                cfg_be_i,
  input  logic [31:0]               cfg_data_i,
  input  logic [N_CORES-1:0]        cfg_id_i,
  output logic [31:0]               cfg_r_data_o,
  output logic                      cfg_r_valid_o,
  output logic [N_CORES-1:0]        cfg_r_id_o,
  output logic                      clear_o,
  output logic                      start_o,
  output logic                      busy_o,
  output logic [N_CORES-1:0]        evt_o,
  input  logic                      done_i,
  input  data_t                     result_i,
  output logic                      rf_wen_o,
  output logic                      rf_ren_o,
  output logic [REG_ADDR_WIDTH-1:0] rf_addr_o,
  output logic [CTX_W-1:0]          rf_ctx_o,
  output data_t                     rf_wdata_o,
  input  data_t                     rf_rdata_i,
  output logic                      rf_done_o,
  output data_t                     rf_result_o,
  output logic [CTX_W-1:0]          run_ctx_o,
  output logic [STAT_WIDTH-1:0]     stat_o,
  output logic [ACQ_WIDTH-1:0]      acq_o
);

  typedef enum logic [1:0] {st_idle, st_starting, st_running} run_state_e;

  run_state_e state_q;

  logic [REG_ADDR_WIDTH-1:0]        addr;
  logic                             is_read, is_write, is_trigger, is_acquire, is_soft_clear;
  logic                             is_contexted, full, working, true_done, crit_q;
  logic [CTX_W-1:0]                 pointer_q, run_ctx_q;
  logic [CTX_W:0]                   pending_q;
  logic [N_CONTEXT-1:0][CORE_W-1:0] owner_q;  // Triggering core of each context
  logic [1:0]                       clr_cnt_q;

  assign addr          = cfg_add_i[REG_ADDR_WIDTH+1:2];
  assign is_read       = cfg_req_i & cfg_wen_i;
  assign is_write      = cfg_req_i & ~cfg_wen_i & (&cfg_be_i);  // Full-word writes only
  assign full          = (pending_q == (CTX_W+1)'(N_CONTEXT));
  assign working       = (state_q != st_idle);
  assign true_done     = done_i & working;  // Ignore a stray done while idle
  assign is_trigger    = is_write && (addr == REG_TRIGGER) && !full;
  assign is_acquire    = is_read && (addr == REG_ACQUIRE);
  assign is_soft_clear = is_write && (addr == REG_SOFT_CLEAR);
  assign is_contexted  = (addr == REG_START) || (addr == REG_STRIDE) || (addr == REG_COUNT);

  // Register file access, job writes only inside the critical section
  assign rf_wen_o    = is_write & is_contexted & crit_q;
  assign rf_ren_o    = is_read;
  assign rf_addr_o   = addr;
  assign rf_ctx_o    = pointer_q;
  assign rf_wdata_o  = cfg_data_i;
  assign rf_done_o   = true_done;
  assign rf_result_o = result_i;
  assign run_ctx_o   = run_ctx_q;
  assign stat_o      = {full, working};
  assign acq_o       = full ? ACQUIRE_FULL : ACQ_WIDTH'(pointer_q);
  assign busy_o      = working;
  assign cfg_gnt_o   = 1'b1;
  assign cfg_r_data_o = rf_rdata_i;

  // Context queue
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pointer_q <= '0;
      run_ctx_q <= '0;
      pending_q <= '0;
      owner_q   <= '0;
    end else if (clear_o) begin
      pointer_q <= '0;
      run_ctx_q <= '0;
      pending_q <= '0;
    end else begin
      if (is_trigger) begin
        pointer_q <= pointer_q + 1'b1;
        for (int i = 0; i < N_CORES; i++) begin
          if (cfg_id_i[i]) owner_q[pointer_q] <= CORE_W'(i);
        end
      end
      if (true_done) run_ctx_q <= run_ctx_q + 1'b1;
      if (is_trigger && !true_done) pending_q <= pending_q + 1'b1;
      else if (!is_trigger && true_done) pending_q <= pending_q - 1'b1;
    end
  end

  // Run FSM, the extra starting state keeps start two edges after a trigger
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= st_idle;
      start_o <= 1'b0;
    end else if (clear_o) begin
      state_q <= st_idle;
      start_o <= 1'b0;
    end else begin
      start_o <= 1'b0;
      case (state_q)
        st_idle: if (pending_q != '0 || is_trigger) state_q <= st_starting;
        st_starting: begin
          state_q <= st_running;
          start_o <= 1'b1;
        end
        st_running: if (true_done) state_q <= st_idle;
        default: state_q <= st_idle;
      endcase
    end
  end

  // Critical section between a successful acquire and the trigger
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      crit_q <= 1'b0;
    end else if (clear_o) begin
      crit_q <= 1'b0;
    end else if (is_acquire && !full) begin
      crit_q <= 1'b1;
    end else if (is_trigger) begin
      crit_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      evt_o <= '0;
    end else begin
      for (int i = 0; i < N_CORES; i++) begin
        evt_o[i] <= true_done && (owner_q[run_ctx_q] == CORE_W'(i));
      end
    end
  end

  // Soft clear, counter runs 1..3 and clear follows one edge later
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      clr_cnt_q <= '0;
      clear_o   <= 1'b0;
    end else begin
      if (clr_cnt_q == '0 && is_soft_clear) clr_cnt_q <= 2'd1;
      else if (clr_cnt_q != '0) clr_cnt_q <= clr_cnt_q + 2'd1;
      clear_o <= |clr_cnt_q;
    end
  end

  // Every request gets a response one cycle later
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cfg_r_valid_o <= 1'b0;
      cfg_r_id_o    <= '0;
    end else begin
      cfg_r_valid_o <= cfg_req_i;
      if (cfg_req_i) cfg_r_id_o <= cfg_id_i;
    end
  end

endmodule

// File: src/ctrl_regfile.sv
`timescale 1ns/100ps

module ctrl_regfile
  import hwpe_ctrl_pkg::*;
  import engine_pkg::*;
#(
  parameter int unsigned N_CONTEXT = 2,
  localparam int unsigned CTX_W    = $clog2(N_CONTEXT)
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      clear_i,
  input  logic                      wen_i,
  input  logic                      ren_i,
  input  logic [REG_ADDR_WIDTH-1:0] addr_i,
  input  logic [CTX_W-1:0]          ctx_i,
  input  data_t                     wdata_i,
  output data_t                     rdata_o,
  input  logic [CTX_W-1:0]          run_ctx_i,
  input  logic [STAT_WIDTH-1:0]     stat_i,
  input  logic [ACQ_WIDTH-1:0]      acq_i,
  input  logic                      done_i,
  input  data_t                     result_i,
  output data_t                     start_val_o,
  output data_t                     stride_o,
  output logic [COUNT_WIDTH-1:0]    count_o
);

  data_t start_q  [N_CONTEXT];
  data_t stride_q [N_CONTEXT];
  data_t count_q  [N_CONTEXT];
  data_t result_q;
  data_t finished_q;
  data_t rdata_d;

  // Job registers, one set per context
  always_ff @(posedge clk_i) begin
    if (wen_i) begin
      case (addr_i)
        REG_START:  start_q[ctx_i]  <= wdata_i;
        REG_STRIDE: stride_q[ctx_i] <= wdata_i;
        REG_COUNT:  count_q[ctx_i]  <= wdata_i;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      result_q   <= '0;
      finished_q <= '0;
    end else if (clear_i) begin
      finished_q <= '0;  // RESULT survives a soft clear
    end else if (done_i) begin
      result_q   <= result_i;
      finished_q <= finished_q + 1'b1;
    end
  end

  always_comb begin
    rdata_d = '0;
    case (addr_i)
      REG_ACQUIRE:     rdata_d = DATA_WIDTH'(acq_i);
      REG_FINISHED:    rdata_d = finished_q;
      REG_STATUS:      rdata_d = DATA_WIDTH'(stat_i);
      REG_RUNNING_CTX: rdata_d = DATA_WIDTH'(run_ctx_i);
      REG_RESULT:      rdata_d = result_q;
      REG_START:       rdata_d = start_q[ctx_i];
      REG_STRIDE:      rdata_d = stride_q[ctx_i];
      REG_COUNT:       rdata_d = count_q[ctx_i];
      default:         rdata_d = '0;  // Trigger and clear read as zero
    endcase
  end

  // Response data follows the request by one cycle, writes return zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_o <= '0;
    end else begin
      rdata_o <= ren_i ? rdata_d : '0;
    end
  end

  // Job fields of the context the engine is working on
  assign start_val_o = start_q[run_ctx_i];
  assign stride_o    = stride_q[run_ctx_i];
  assign count_o     = count_q[run_ctx_i][COUNT_WIDTH-1:0];

endmodule

// File: src/engine_pkg.sv
package engine_pkg;

  // Stream word and job field width
  localparam int unsigned DATA_WIDTH = 32;

  // Width of the item counters in the source and the sink
  localparam int unsigned COUNT_WIDTH = 16;

  typedef logic [DATA_WIDTH-1:0] data_t;

endpackage

// File: src/hwpe_ctrl_pkg.sv
package hwpe_ctrl_pkg;

  // Word addresses of the control register map
  localparam int unsigned REG_TRIGGER     = 0;  // Write starts the prepared job
  localparam int unsigned REG_ACQUIRE     = 1;  // Read returns free context, opens critical section
  localparam int unsigned REG_FINISHED    = 2;  // Completed job counter
  localparam int unsigned REG_STATUS      = 3;  // Bit 0 working, bit 1 queue full
  localparam int unsigned REG_RUNNING_CTX = 4;
  localparam int unsigned REG_SOFT_CLEAR  = 5;  // Write starts the three-cycle clear
  localparam int unsigned REG_RESULT      = 6;  // Sum of the last finished job

  // Contexted job registers
  localparam int unsigned REG_START  = 8;
  localparam int unsigned REG_STRIDE = 9;
  localparam int unsigned REG_COUNT  = 10;

  // Word address bits, taken from byte address bits 5:2
  localparam int unsigned REG_ADDR_WIDTH = 4;

  // Default number of cores sharing the engine
  localparam int unsigned N_CORES_DEF = 2;

  // Default number of job contexts, power of two and at least 2
  localparam int unsigned N_CONTEXT_DEF = 2;

  // Acquire result width and the marker returned when no context is free
  localparam int unsigned ACQ_WIDTH = 8;
  localparam logic [ACQ_WIDTH-1:0] ACQUIRE_FULL = 8'd255;

  // Width of the status word packed as {full, working}
  localparam int unsigned STAT_WIDTH = 2;

endpackage
